// File: Bender.yml
package:
  name: mmioClient

export_include_dirs:
  - include

sources:
  # Packages before the modules that import them
  - hdl/mmioRegPkg.sv
  - hdl/mmioMemPkg.sv
  - hdl/mmioXmem.sv
  - hdl/mmioRegFile.sv
  - hdl/mmioBusCtrl.sv
  - hdl/mmioClient.sv

  - target: simulation
    files:
      - bench/mmioClientTb.sv

// File: include/mmioClientTbTasks.svh
// --------------------------------------------------
// Host bus tasks
// --------------------------------------------------
// Every task starts and returns 1 ns after a rising edge

task automatic hostWrite(input mmioAddr_t a, input mmioByte_t d);
  csN    = 1'b0;
  weN    = 1'b0;            // Write
  addr   = a;
  wrData = d;
  @(posedge shlClk);
  #1;
  csN = 1'b1;
  weN = 1'b1;
endtask

task automatic hostRead(input mmioAddr_t a, output mmioByte_t d);
  int waitCnt;
  csN     = 1'b0;
  weN     = 1'b1;
  addr    = a;
  waitCnt = 0;
  @(posedge shlClk);
  #1;
  csN = 1'b1;
  while (!rdValid)
  begin
    if (waitCnt == ReadTimeout)
      reportFailure($sformatf("Timeout waiting for rdValid after read of %02h", a));
    else
    begin
      @(posedge shlClk);
      #1;
      waitCnt++;
    end
  end
  d = rdData;
endtask

task automatic readCheck(input string testName, input mmioAddr_t a, input mmioByte_t expected);
  mmioByte_t got;
  hostRead(a, got);
  checkByte(testName, $sformatf("read of %02h", a), expected, got);
endtask

// --------------------------------------------------
// Fabric port tasks
// --------------------------------------------------
task automatic fabricWrite(input xmemWordAddr_t wa, input xmemWord_u d);
  xmemEn     = 1'b1;
  xmemWrEn   = 1'b1;
  xmemAddr   = wa;
  xmemWrData = d;
  @(posedge shlClk);
  #1;
  xmemEn   = 1'b0;
  xmemWrEn = 1'b0;
endtask

task automatic fabricRead(input xmemWordAddr_t wa, output xmemWord_u d);
  xmemEn   = 1'b1;
  xmemWrEn = 1'b0;
  xmemAddr = wa;
  @(posedge shlClk);
  #1;
  xmemEn = 1'b0;
  d      = xmemRdData;  // Fixed one cycle latency
endtask

// --------------------------------------------------
// Typed compares
// --------------------------------------------------
task automatic checkByte(input string testName, input string item,
                         input mmioByte_t expected, input mmioByte_t actual);
  if (actual !== expected)
  begin
    $display("** Error [%s] %s expected %02h actual %02h", testName, item, expected, actual);
    reportFailure("");
  end
endtask

task automatic checkWord(input string testName, input xmemWord_u expected,
                         input xmemWord_u actual);
  if (actual !== expected)
  begin
    $display("** Error [%s] fabric word expected %08h actual %08h",
             testName, expected.word, actual.word);
    reportFailure("");
  end
endtask

// File: bench/mmioClientTb.sv
`include "mmioClient_settings.svh"

module mmioClientTb
  import mmioRegPkg::*;
  import mmioMemPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam mmioByte_t TopYear  = 8'h2A;
  localparam mmioByte_t TopMonth = 8'h07;
  localparam mmioByte_t TopDay   = 8'h15;
  localparam int        ReadTimeout = 16;  // Cycles

  logic          shlClk;
  logic          rstN;
  logic          csN;
  logic          weN;
  mmioAddr_t     addr;
  mmioByte_t     wrData;
  mmioByte_t     rdData;
  logic          rdValid;
  logic          mc0CalDone;
  logic          mc1CalDone;
  logic          ethCoreReady;
  logic          ethQpllLock;
  logic          rxEqualizerMode;
  logic [3:0]    txDriverSwing;
  logic [4:0]    txPreCursor;
  logic [4:0]    txPostCursor;
  logic          pcsLoopbackEn;
  logic          macLoopbackEn;
  logic          macAddrSwapEn;
  logic [47:0]   macAddress;
  logic [31:0]   ipAddress;
  logic [1:0]    udpEchoCtrl;
  logic          udpPostPktEn;
  logic          udpCaptPktEn;
  logic [1:0]    tcpEchoCtrl;
  logic          tcpPostPktEn;
  logic          tcpCaptPktEn;
  logic          xmemEn;
  logic          xmemWrEn;
  xmemWordAddr_t xmemAddr;
  xmemWord_u     xmemWrData;
  xmemWord_u     xmemRdData;
  logic [31:0]   lcgState;

  mmioClient #(
    .topYear  (TopYear),
    .topMonth (TopMonth),
    .topDay   (TopDay)
  ) dut (
    .shlClk, .rstN, .csN, .weN, .addr, .wrData, .rdData, .rdValid,
    .mc0CalDone, .mc1CalDone, .ethCoreReady, .ethQpllLock,
    .rxEqualizerMode, .txDriverSwing, .txPreCursor, .txPostCursor,
    .pcsLoopbackEn, .macLoopbackEn, .macAddrSwapEn, .macAddress, .ipAddress,
    .udpEchoCtrl, .udpPostPktEn, .udpCaptPktEn,
    .tcpEchoCtrl, .tcpPostPktEn, .tcpCaptPktEn,
    .xmemEn, .xmemWrEn, .xmemAddr, .xmemWrData, .xmemRdData
  );

  initial
  begin
    shlClk = 1'b0;
    forever #4 shlClk = ~shlClk;  // 8 ns period
  end

  // Stops the run at the first problem
  task automatic reportFailure(input string reason);
    if (reason != "")
      $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  // Numerical Recipes LCG
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic mmioByte_t randByte();
    logic [31:0] r;
    r = nextRand();
    return r[23:16];  // Upper bits are the better ones
  endfunction

  // Decoded outputs packed back into byte form
  function automatic mmioByte_t eqSwingView();
    return {txDriverSwing, 3'b000, rxEqualizerMode};
  endfunction

  function automatic mmioByte_t loopbackView();
    return {5'b00000, macAddrSwapEn, macLoopbackEn, pcsLoopbackEn};
  endfunction

  function automatic mmioByte_t roleView();
    return {tcpCaptPktEn, tcpPostPktEn, tcpEchoCtrl, udpCaptPktEn, udpPostPktEn, udpEchoCtrl};
  endfunction

  `include "mmioClientTbTasks.svh"

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic testResetValues();
    mmioByte_t eth0;
    mmioByte_t eth1;
    mmioByte_t eth2;
    eth0 = `ETH0_RST0;
    eth1 = `ETH0_RST1;
    eth2 = `ETH0_RST2;
    for (int c = 0; c < 3; c++)
    begin
      if (rdValid !== 1'b0)
        reportFailure("rdValid went high after reset with no read issued");
      else
      begin
        @(posedge shlClk);
        #1;
      end
    end
    checkByte("resetValues", "eq and swing", {eth0[7:4], 3'b000, eth0[0]}, eqSwingView());
    checkByte("resetValues", "pre cursor", {3'b000, eth1[4:0]}, {3'b000, txPreCursor});
    checkByte("resetValues", "post cursor", {3'b000, eth2[4:0]}, {3'b000, txPostCursor});
    checkByte("resetValues", "loopback", 8'h00, loopbackView());
    checkByte("resetValues", "role", 8'h00, roleView());
    readCheck("resetValues", {1'b0, `REG_CFG_EMIF_ID}, `EMIF_ID);
    readCheck("resetValues", {1'b0, `REG_CFG_EMIF_VER}, `EMIF_VER);
    readCheck("resetValues", {1'b0, `REG_CFG_EMIF_REV}, `EMIF_REV);
    readCheck("resetValues", {1'b0, `REG_CFG_TOP_ID}, `TOP_ID);
    readCheck("resetValues", {1'b0, `REG_CFG_TOP_YEAR}, TopYear);
    readCheck("resetValues", {1'b0, `REG_CFG_TOP_MONTH}, TopMonth);
    readCheck("resetValues", {1'b0, `REG_CFG_TOP_DAY}, TopDay);
    readCheck("resetValues", mmioAddr_t'(`REG_DIAG_SCRATCH0), 8'hDE);
    readCheck("resetValues", mmioAddr_t'(`REG_DIAG_SCRATCH0 + 1), 8'hAD);
    readCheck("resetValues", mmioAddr_t'(`REG_DIAG_SCRATCH0 + 2), 8'hBE);
    readCheck("resetValues", mmioAddr_t'(`REG_DIAG_SCRATCH0 + 3), 8'hEF);
    readCheck("resetValues", {1'b0, `REG_PAGE_SEL}, 8'h00);  // Page 0 out of reset
  endtask

  task automatic testRegisterRw();
    mmioByte_t macB [6];
    mmioByte_t ipB [4];
    mmioByte_t ethB [3];
    mmioByte_t loopB;
    mmioByte_t roleB;
    foreach (macB[i])
    begin
      macB[i] = randByte();
      hostWrite(mmioAddr_t'(`REG_LY2_MAC0 + i), macB[i]);
    end
    foreach (ipB[i])
    begin
      ipB[i] = randByte();
      hostWrite(mmioAddr_t'(`REG_LY3_IP0 + i), ipB[i]);
    end
    foreach (ethB[i])
    begin
      ethB[i] = randByte();
      hostWrite(mmioAddr_t'(`REG_PHY_ETH0 + i), ethB[i]);
    end
    loopB = randByte();
    roleB = randByte();
    hostWrite({1'b0, `REG_DIAG_CTRL1}, loopB);
    hostWrite({1'b0, `REG_DIAG_CTRL2}, roleB);

    // Read back and compare the fabric side
    foreach (macB[i])
    begin
      readCheck("registerRw", mmioAddr_t'(`REG_LY2_MAC0 + i), macB[i]);
      checkByte("registerRw", "macAddress byte", macB[i], macAddress[8 * i +: 8]);
    end
    foreach (ipB[i])
    begin
      readCheck("registerRw", mmioAddr_t'(`REG_LY3_IP0 + i), ipB[i]);
      checkByte("registerRw", "ipAddress byte", ipB[i], ipAddress[8 * i +: 8]);
    end
    foreach (ethB[i])
      readCheck("registerRw", mmioAddr_t'(`REG_PHY_ETH0 + i), ethB[i]);
    checkByte("registerRw", "eq and swing", {ethB[0][7:4], 3'b000, ethB[0][0]}, eqSwingView());
    checkByte("registerRw", "pre cursor", {3'b000, ethB[1][4:0]}, {3'b000, txPreCursor});
    checkByte("registerRw", "post cursor", {3'b000, ethB[2][4:0]}, {3'b000, txPostCursor});
    readCheck("registerRw", {1'b0, `REG_DIAG_CTRL1}, loopB);
    checkByte("registerRw", "loopback", {5'b00000, loopB[2:0]}, loopbackView());
    readCheck("registerRw", {1'b0, `REG_DIAG_CTRL2}, roleB);
    checkByte("registerRw", "role", roleB, roleView());

    // Read-only and unmapped writes are dropped
    hostWrite({1'b0, `REG_CFG_EMIF_ID}, ~`EMIF_ID);
    readCheck("registerRw", {1'b0, `REG_CFG_EMIF_ID}, `EMIF_ID);
    hostWrite({1'b0, `REG_CFG_TOP_YEAR}, ~TopYear);
    readCheck("registerRw", {1'b0, `REG_CFG_TOP_YEAR}, TopYear);
    hostWrite(8'h08, 8'hA5);
    readCheck("registerRw", 8'h08, 8'h00);
    hostWrite(8'h5A, randByte());
    readCheck("registerRw", 8'h5A, 8'h00);
    checkByte("registerRw", "macAddress byte after dropped writes", macB[0], macAddress[7:0]);
  endtask

  task automatic testStatusByte();
    logic [3:0] combo;
    for (int c = 0; c < 16; c++)
    begin
      combo        = 4'(c);
      mc0CalDone   = combo[0];
      mc1CalDone   = combo[1];
      ethCoreReady = combo[2];
      ethQpllLock  = combo[3];
      readCheck("statusByte", {1'b0, `REG_PHY_STAT}, {4'b0000, combo});
    end
  endtask

  task automatic testPagedWrites();
    int        pageList [3];
    int        off;
    mmioByte_t d;
    xmemWord_u expected;
    xmemWord_u got;
    pageList = '{0, 5, 15};
    foreach (pageList[p])
    begin
      hostWrite({1'b0, `REG_PAGE_SEL}, mmioByte_t'(pageList[p]));
      off = (randByte() % 32) * 4;  // Whole word from four lanes
      for (int l = 0; l < 4; l++)
      begin
        d = randByte();
        expected.word[8 * l +: 8] = d;
        hostWrite(mmioAddr_t'(128 + off + l), d);
      end
      fabricRead(xmemWordAddr_t'((pageList[p] * 128 + off) / 4), got);
      checkWord("pagedWrites", expected, got);
      for (int k = 0; k < 3; k++)
      begin
        off = randByte() % 128;
        d   = randByte();
        hostWrite(mmioAddr_t'(128 + off), d);
        fabricRead(xmemWordAddr_t'((pageList[p] * 128 + off) / 4), got);
        checkByte("pagedWrites", $sformatf("page %0d offset %02h", pageList[p], off),
                  d, got.word[8 * (off % 4) +: 8]);
      end
    end
  endtask

  task automatic testFabricWrites();
    logic [31:0]   val;
    xmemWordAddr_t wa;
    xmemWord_u     wd;
    xmemWord_u     got;
    int            off;
    for (int k = 0; k < 4; k++)
    begin
      val     = nextRand();
      wa      = xmemWordAddr_t'(nextRand() >> 20);
      wd.word = val;
      fabricWrite(wa, wd);
      fabricRead(wa, got);
      checkWord("fabricWrites", wd, got);
      hostWrite({1'b0, `REG_PAGE_SEL}, mmioByte_t'(wa / 32));  // 32 words per page
      for (int l = 0; l < 4; l++)
      begin
        off = (wa % 32) * 4 + l;
        readCheck("fabricWrites", mmioAddr_t'(128 + off), val[8 * l +: 8]);
      end
    end
  endtask

  task automatic testBackToBack();
    mmioAddr_t addrList [8];
    mmioByte_t expList [8];
    mmioByte_t memB [4];
    hostWrite({1'b0, `REG_PAGE_SEL}, 8'h03);
    foreach (memB[l])
    begin
      memB[l] = randByte();
      hostWrite(mmioAddr_t'(8'h90 + l), memB[l]);
    end
    // Windows alternate so the return mux switches every cycle
    addrList = '{8'h90, {1'b0, `REG_CFG_EMIF_ID}, 8'h91, {1'b0, `REG_DIAG_SCRATCH0},
                 8'h92, 8'h93, {1'b0, `REG_PAGE_SEL}, {1'b0, `REG_CFG_TOP_ID}};
    expList  = '{memB[0], `EMIF_ID, memB[1], 8'hDE, memB[2], memB[3], 8'h03, `TOP_ID};
    foreach (addrList[i])
    begin
      csN  = 1'b0;
      weN  = 1'b1;
      addr = addrList[i];
      @(posedge shlClk);
      #1;
      if (rdValid !== 1'b1)
        reportFailure($sformatf("rdValid low one cycle after back-to-back read %0d", i));
      else
        checkByte("backToBack", $sformatf("read %0d of %02h", i, addrList[i]),
                  expList[i], rdData);
    end
    csN = 1'b1;
  endtask

  // --------------------------------------------------
  // Sequence
  // --------------------------------------------------
  initial
  begin
    rstN         = 1'b0;
    csN          = 1'b1;
    weN          = 1'b1;
    addr         = '0;
    wrData       = '0;
    mc0CalDone   = 1'b0;
    mc1CalDone   = 1'b0;
    ethCoreReady = 1'b0;
    ethQpllLock  = 1'b0;
    xmemEn       = 1'b0;
    xmemWrEn     = 1'b0;
    xmemAddr     = '0;
    xmemWrData   = '0;
    lcgState     = 32'h4c26;
    repeat (5) @(posedge shlClk);
    #1;
    rstN = 1'b1;

    testResetValues();
    testRegisterRw();
    testStatusByte();
    testPagedWrites();
    testFabricWrites();
    testBackToBack();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: hdl/mmioBusCtrl.sv
`include "mmioClient_settings.svh"

module mmioBusCtrl
  import mmioRegPkg::*;
  import mmioMemPkg::*;
(
  input  logic          shlClk,
  input  logic          rstN,
  input  logic          csN,
  input  logic          weN,
  input  mmioAddr_t     addr,
  input  mmioByte_t     wrData,
  input  mmioByte_t     pageSel,
  input  mmioByte_t     regRdData,  // Combinational from the register file
  input  mmioByte_t     memRdData,  // One cycle after memEn
  output logic          regWrEn,
  output regIdx_t       regIdx,
  output mmioByte_t     regWrData,
  output logic          memEn,
  output logic          memWrEn,
  output xmemByteAddr_t memAddr,
  output mmioByte_t     memWrData,
  output mmioByte_t     rdData,
  output logic          rdValid
);

  localparam int WinBit      = `MMIO_ADDR_W - 1;
  localparam int PageSelBits = $bits(xmemByteAddr_t) - `MMIO_PAGE_BITS;  // 4 of 8 used

  logic      memWin;    // Access targets the upper window
  logic      rdReq;
  logic      memWinQ;   // Window of the read in flight
  mmioByte_t regRdQ;

  // --------------------------------------------------
  // Access decode
  // --------------------------------------------------
  assign memWin = addr[WinBit];
  assign rdReq  = !csN && weN;

  // Register file side
  assign regIdx    = addr[`MMIO_PAGE_BITS-1:0];
  assign regWrEn   = !csN && !weN && !memWin;  // Commits at this edge
  assign regWrData = wrData;

  // Memory side, page on top of the offset
  assign memEn     = !csN && memWin;
  assign memWrEn   = !weN;
  assign memAddr   = {pageSel[PageSelBits-1:0], addr[`MMIO_PAGE_BITS-1:0]};
  assign memWrData = wrData;

  // --------------------------------------------------
  // Read return
  // --------------------------------------------------
  always_ff @(posedge shlClk or negedge rstN)
  begin
    if (!rstN)
    begin
      rdValid <= 1'b0;
      memWinQ <= 1'b0;
    end
    else
    begin
      rdValid <= rdReq;
      if (rdReq)
        memWinQ <= memWin;  // Remember where the byte comes from
    end
  end

  // Register byte sampled to line up with the memory latency
  always_ff @(posedge shlClk)
  begin
    if (rdReq && !memWin)
      regRdQ <= regRdData;
  end

  assign rdData = memWinQ ? memRdData : regRdQ;

  // Every returned byte belongs to a read of the previous cycle
  assert property (@(posedge shlClk) disable iff (!rstN)
    rdValid |-> $past(!csN && weN));

  // A host access reaches one target only
  assert property (@(posedge shlClk) disable iff (!rstN)
    !(memEn && regWrEn));

endmodule

// File: hdl/mmioClient.sv
module mmioClient
  import mmioRegPkg::*;
  import mmioMemPkg::*;
#(
  parameter mmioByte_t topYear  = 8'hFF,
  parameter mmioByte_t topMonth = 8'hFF,
  parameter mmioByte_t topDay   = 8'hFF
) (
  input  logic          shlClk,
  input  logic          rstN,

  // Host bus
  input  logic          csN,
  input  logic          weN,           // Low for write
  input  mmioAddr_t     addr,
  input  mmioByte_t     wrData,
  output mmioByte_t     rdData,
  output logic          rdValid,

  // Shell status
  input  logic          mc0CalDone,
  input  logic          mc1CalDone,
  input  logic          ethCoreReady,
  input  logic          ethQpllLock,

  // Ethernet tuning and loopback
  output logic          rxEqualizerMode,
  output logic [3:0]    txDriverSwing,
  output logic [4:0]    txPreCursor,
  output logic [4:0]    txPostCursor,
  output logic          pcsLoopbackEn,
  output logic          macLoopbackEn,
  output logic          macAddrSwapEn,
  output logic [47:0]   macAddress,
  output logic [31:0]   ipAddress,

  // Role control
  output logic [1:0]    udpEchoCtrl,
  output logic          udpPostPktEn,
  output logic          udpCaptPktEn,
  output logic [1:0]    tcpEchoCtrl,
  output logic          tcpPostPktEn,
  output logic          tcpCaptPktEn,

  // Fabric memory port
  input  logic          xmemEn,
  input  logic          xmemWrEn,
  input  xmemWordAddr_t xmemAddr,
  input  xmemWord_u     xmemWrData,
  output xmemWord_u     xmemRdData
);

  logic          regWrEn;
  regIdx_t       regIdx;
  mmioByte_t     regWrData;
  mmioByte_t     regRdData;
  mmioByte_t     pageSel;    // Upper window page
  logic          memEn;
  logic          memWrEn;
  xmemByteAddr_t memAddr;
  mmioByte_t     memWrData;
  mmioByte_t     memRdData;

  mmioBusCtrl busCtrl (
    .shlClk, .rstN, .csN, .weN, .addr, .wrData,
    .pageSel, .regRdData, .memRdData,
    .regWrEn, .regIdx, .regWrData,
    .memEn, .memWrEn, .memAddr, .memWrData,
    .rdData, .rdValid
  );

  mmioRegFile #(
    .topYear  (topYear),
    .topMonth (topMonth),
    .topDay   (topDay)
  ) regFile (
    .shlClk, .rstN, .regWrEn, .regIdx, .regWrData,
    .mc0CalDone, .mc1CalDone, .ethCoreReady, .ethQpllLock,
    .regRdData, .pageSel,
    .rxEqualizerMode, .txDriverSwing, .txPreCursor, .txPostCursor,
    .pcsLoopbackEn, .macLoopbackEn, .macAddrSwapEn, .macAddress, .ipAddress,
    .udpEchoCtrl, .udpPostPktEn, .udpCaptPktEn,
    .tcpEchoCtrl, .tcpPostPktEn, .tcpCaptPktEn
  );

  mmioXmem xmem (
    .shlClk, .memEn, .memWrEn, .memAddr, .memWrData, .memRdData,
    .xmemEn, .xmemWrEn, .xmemAddr, .xmemWrData, .xmemRdData
  );

endmodule

// File: hdl/mmioMemPkg.sv
`include "mmioClient_settings.svh"

package mmioMemPkg;

  localparam int ByteAddrW = $clog2(`XMEM_BYTES);  // 11
  localparam int WordAddrW = $clog2(`XMEM_WORDS);  // 9
  localparam int LaneCount = `XMEM_WORD_W / `MMIO_DATA_W;

  typedef logic [ByteAddrW-1:0] xmemByteAddr_t;  // Host view, page and offset
  typedef logic [WordAddrW-1:0] xmemWordAddr_t;  // Fabric view

  // One storage word, seen whole by the fabric and as byte lanes by the host
  typedef union packed
  {
    logic [`XMEM_WORD_W-1:0]                  word;
    logic [LaneCount-1:0][`MMIO_DATA_W-1:0]   lane;  // Lane 0 is bits 7:0
  } xmemWord_u;

endpackage

// File: hdl/mmioRegFile.sv
`include "mmioClient_settings.svh"

module mmioRegFile
  import mmioRegPkg::*;
#(
  parameter mmioByte_t topYear  = 8'hFF,
  parameter mmioByte_t topMonth = 8'hFF,
  parameter mmioByte_t topDay   = 8'hFF
) (
  input  logic        shlClk,
  input  logic        rstN,
  input  logic        regWrEn,
  input  regIdx_t     regIdx,
  input  mmioByte_t   regWrData,
  input  logic        mc0CalDone,
  input  logic        mc1CalDone,
  input  logic        ethCoreReady,
  input  logic        ethQpllLock,
  output mmioByte_t   regRdData,
  output mmioByte_t   pageSel,
  output logic        rxEqualizerMode,
  output logic [3:0]  txDriverSwing,
  output logic [4:0]  txPreCursor,
  output logic [4:0]  txPostCursor,
  output logic        pcsLoopbackEn,
  output logic        macLoopbackEn,
  output logic        macAddrSwapEn,
  output logic [47:0] macAddress,
  output logic [31:0] ipAddress,
  output logic [1:0]  udpEchoCtrl,
  output logic        udpPostPktEn,
  output logic        udpCaptPktEn,
  output logic [1:0]  tcpEchoCtrl,
  output logic        tcpPostPktEn,
  output logic        tcpCaptPktEn
);

  localparam int RegCount = 2 ** `MMIO_PAGE_BITS;

  mmioByte_t regQ  [RegCount];  // Writable bytes, others stay at reset
  mmioByte_t rdMux [RegCount];  // Host view of every index
  mmioByte_t statByte;
  mmioByte_t eth0, eth1, eth2;
  mmioByte_t ctrl1, ctrl2;

  // Reset byte of each writable index
  function automatic mmioByte_t rstByte(regIdx_t idx);
    case (idx)
      `REG_PHY_ETH0:          return `ETH0_RST0;
      `REG_PHY_ETH0 + 1:      return `ETH0_RST1;
      `REG_PHY_ETH0 + 2:      return `ETH0_RST2;
      `REG_DIAG_SCRATCH0:     return `SCRATCH_RST0;
      `REG_DIAG_SCRATCH0 + 1: return `SCRATCH_RST1;
      `REG_DIAG_SCRATCH0 + 2: return `SCRATCH_RST2;
      `REG_DIAG_SCRATCH0 + 3: return `SCRATCH_RST3;
      default:                return '0;  // MAC, IP, controls, page
    endcase
  endfunction

  // Burned-in identification
  function automatic mmioByte_t idByte(regIdx_t idx);
    case (idx)
      `REG_CFG_EMIF_ID:   return `EMIF_ID;
      `REG_CFG_EMIF_VER:  return `EMIF_VER;
      `REG_CFG_EMIF_REV:  return `EMIF_REV;
      `REG_CFG_TOP_ID:    return `TOP_ID;
      `REG_CFG_TOP_YEAR:  return topYear;
      `REG_CFG_TOP_MONTH: return topMonth;
      `REG_CFG_TOP_DAY:   return topDay;
      default:            return '0;
    endcase
  endfunction

  // --------------------------------------------------
  // Host writes
  // --------------------------------------------------
  always_ff @(posedge shlClk or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < RegCount; i++)
        regQ[i] <= rstByte(regIdx_t'(i));
    end
    else if (regWrEn && regAccess(regIdx) == ACC_RW)
      regQ[regIdx] <= regWrData;  // RO and unmapped writes dropped
  end

  // Cal done, core ready and PLL lock in the low nibble
  assign statByte = {4'b0000, ethQpllLock, ethCoreReady, mc1CalDone, mc0CalDone};

  // --------------------------------------------------
  // Host reads
  // --------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < RegCount; i++)
    begin
      case (regAccess(regIdx_t'(i)))
        ACC_ID:   rdMux[i] = idByte(regIdx_t'(i));
        ACC_STAT: rdMux[i] = statByte;
        ACC_RW:   rdMux[i] = regQ[i];
        default:  rdMux[i] = '0;
      endcase
    end
  end

  assign regRdData = rdMux[regIdx];

  // --------------------------------------------------
  // Fabric outputs
  // --------------------------------------------------
  assign eth0  = regQ[`REG_PHY_ETH0];
  assign eth1  = regQ[`REG_PHY_ETH0 + 1];
  assign eth2  = regQ[`REG_PHY_ETH0 + 2];
  assign ctrl1 = regQ[`REG_DIAG_CTRL1];
  assign ctrl2 = regQ[`REG_DIAG_CTRL2];

  assign rxEqualizerMode = eth0[0];
  assign txDriverSwing   = eth0[7:4];  // Bits 3:1 spare
  assign txPreCursor     = eth1[4:0];
  assign txPostCursor    = eth2[4:0];

  assign macAddress = {regQ[`REG_LY2_MAC0 + 5], regQ[`REG_LY2_MAC0 + 4],
                       regQ[`REG_LY2_MAC0 + 3], regQ[`REG_LY2_MAC0 + 2],
                       regQ[`REG_LY2_MAC0 + 1], regQ[`REG_LY2_MAC0]};
  assign ipAddress  = {regQ[`REG_LY3_IP0 + 3], regQ[`REG_LY3_IP0 + 2],
                       regQ[`REG_LY3_IP0 + 1], regQ[`REG_LY3_IP0]};

  // Loopback control
  assign pcsLoopbackEn = ctrl1[0];
  assign macLoopbackEn = ctrl1[1];
  assign macAddrSwapEn = ctrl1[2];

  // Role control, UDP low nibble and TCP high nibble
  assign udpEchoCtrl  = ctrl2[1:0];
  assign udpPostPktEn = ctrl2[2];
  assign udpCaptPktEn = ctrl2[3];
  assign tcpEchoCtrl  = ctrl2[5:4];
  assign tcpPostPktEn = ctrl2[6];
  assign tcpCaptPktEn = ctrl2[7];

  assign pageSel = regQ[`REG_PAGE_SEL];

  // Identification bytes survive a host write
  assert property (@(posedge shlClk) disable iff (!rstN)
    (regWrEn && regAccess(regIdx) == ACC_ID) |=> rdMux[$past(regIdx)] == $past(regRdData));

endmodule

// File: hdl/mmioRegPkg.sv
`include "mmioClient_settings.svh"

package mmioRegPkg;

  typedef logic [`MMIO_ADDR_W-1:0]    mmioAddr_t;  // Full host address
  typedef logic [`MMIO_DATA_W-1:0]    mmioByte_t;
  typedef logic [`MMIO_PAGE_BITS-1:0] regIdx_t;    // Offset inside the lower window

  // How a register index behaves on the host bus
  typedef enum logic [1:0]
  {
    ACC_NONE,  // Unmapped, reads zero
    ACC_ID,    // Fixed identification byte
    ACC_STAT,  // Live status from the shell
    ACC_RW     // Host writable
  } regAcc_t;

  // --------------------------------------------------
  // Register map decode
  // --------------------------------------------------
  function automatic regAcc_t regAccess(regIdx_t idx);
    regAcc_t acc;
    acc = ACC_NONE;
    if (idx inside {`REG_CFG_EMIF_ID, `REG_CFG_EMIF_VER, `REG_CFG_EMIF_REV,
                    [`REG_CFG_TOP_ID : `REG_CFG_TOP_DAY]})
      acc = ACC_ID;
    else if (idx == `REG_PHY_STAT)
      acc = ACC_STAT;
    else if (idx inside {[`REG_PHY_ETH0 : `REG_PHY_ETH0 + 2],
                         [`REG_LY2_MAC0 : `REG_LY2_MAC0 + 5],
                         [`REG_LY3_IP0 : `REG_LY3_IP0 + 3],
                         [`REG_DIAG_SCRATCH0 : `REG_DIAG_SCRATCH0 + 3],
                         `REG_DIAG_CTRL1, `REG_DIAG_CTRL2, `REG_PAGE_SEL})
      acc = ACC_RW;
    return acc;
  endfunction

endpackage

// File: hdl/mmioXmem.sv
`include "mmioClient_settings.svh"

module mmioXmem
  import mmioRegPkg::*;
  import mmioMemPkg::*;
(
  input  logic          shlClk,

  // Host side, byte wide
  input  logic          memEn,
  input  logic          memWrEn,
  input  xmemByteAddr_t memAddr,
  input  mmioByte_t     memWrData,
  output mmioByte_t     memRdData,

  // Fabric side, word wide
  input  logic          xmemEn,
  input  logic          xmemWrEn,
  input  xmemWordAddr_t xmemAddr,
  input  xmemWord_u     xmemWrData,
  output xmemWord_u     xmemRdData
);

  localparam int LaneBits = $clog2(`XMEM_WORD_W / `MMIO_DATA_W);

  xmemWord_u mem [`XMEM_WORDS];

  xmemWordAddr_t          hostWord;
  logic [LaneBits-1:0]    hostLane;

  // Byte address splits into word and lane
  assign hostWord = memAddr[$bits(xmemByteAddr_t)-1:LaneBits];
  assign hostLane = memAddr[LaneBits-1:0];

  // --------------------------------------------------
  // Both ports, read-first
  // --------------------------------------------------
  always_ff @(posedge shlClk)
  begin
    // Fabric moves whole words
    if (xmemEn)
    begin
      if (xmemWrEn)
        mem[xmemAddr].word <= xmemWrData.word;
      xmemRdData <= mem[xmemAddr];
    end

    // Host touches one lane
    if (memEn)
    begin
      if (memWrEn)
        mem[hostWord].lane[hostLane] <= memWrData;  // Same word as fabric is undefined
      memRdData <= mem[hostWord].lane[hostLane];
    end
  end

  // Fabric address must be clean when used
  assert property (@(posedge shlClk)
    xmemEn |-> !$isunknown(xmemAddr));

endmodule

// File: include/mmioClient_settings.svh
`ifndef MMIO_CLIENT_SETTINGS_SVH
`define MMIO_CLIENT_SETTINGS_SVH

// --------------------------------------------------
// Bus and memory geometry
// --------------------------------------------------
`define MMIO_ADDR_W         8      // Host address bits, bit 7 picks the window
`define MMIO_DATA_W         8
`define MMIO_PAGE_BITS      7      // 128 bytes per window or page
`define XMEM_WORD_W         32     // Fabric side word
`define XMEM_BYTES          2048
`define XMEM_WORDS          512

// --------------------------------------------------
// Register offsets in the lower window
// --------------------------------------------------
`define REG_CFG_EMIF_ID     7'h00
`define REG_CFG_EMIF_VER    7'h01
`define REG_CFG_EMIF_REV    7'h02
`define REG_CFG_TOP_ID      7'h04
`define REG_CFG_TOP_YEAR    7'h05
`define REG_CFG_TOP_MONTH   7'h06
`define REG_CFG_TOP_DAY     7'h07
`define REG_PHY_STAT        7'h10
`define REG_PHY_ETH0        7'h11  // Three tuning bytes
`define REG_LY2_MAC0        7'h22  // Six bytes, MAC0 is the low byte
`define REG_LY3_IP0         7'h34  // Four bytes, IP0 is the low byte
`define REG_DIAG_SCRATCH0   7'h70
`define REG_DIAG_CTRL1      7'h74  // Loopback control
`define REG_DIAG_CTRL2      7'h76  // Role control
`define REG_PAGE_SEL        7'h7F

// Identification bytes
`define EMIF_ID             8'h3D
`define EMIF_VER            8'h01
`define EMIF_REV            8'h00
`define TOP_ID              8'h01

// Reset bytes
`define ETH0_RST0           8'h41  // Equalizer on, swing 4
`define ETH0_RST1           8'h05
`define ETH0_RST2           8'h05
`define SCRATCH_RST0        8'hDE
`define SCRATCH_RST1        8'hAD
`define SCRATCH_RST2        8'hBE
`define SCRATCH_RST3        8'hEF

`endif

// File: mmioClient.f
+incdir+include
hdl/mmioRegPkg.sv
hdl/mmioMemPkg.sv
hdl/mmioXmem.sv
hdl/mmioRegFile.sv
hdl/mmioBusCtrl.sv
hdl/mmioClient.sv
bench/mmioClientTb.sv
